// ==== design/usi_consts.svh ====
//----------------------------------------------------------
// USI bus widths and block address map
// TFT timing register widths and reset defaults
//----------------------------------------------------------
`ifndef USI_CONSTS_SVH
`define USI_CONSTS_SVH

// Bus widths
`define USI_DATA_WIDTH 32
`define USI_ADRS_WIDTH 32

// Address bits 19:16 select the block, 15:0 the CSR
`define USI_BLOCK_LSB 16
`define USI_CSR_WIDTH 16

// Block numbers
`define USI_BLOCK_GPIO 1
`define USI_BLOCK_VTB 4

// TFT timing register widths
`define TFT_H_WIDTH 11
`define TFT_V_WIDTH 11

// 480x272 panel defaults
`define TFT_HDISPLAY_DEF 480
`define TFT_HFRONT_DEF 8
`define TFT_HBACK_DEF 43
`define TFT_HPULSE_DEF 30
`define TFT_VDISPLAY_DEF 272
`define TFT_VFRONT_DEF 12
`define TFT_VBACK_DEF 4
`define TFT_VPULSE_DEF 10

`endif

// ==== design/usiPkg.sv ====
//----------------------------------------------------------
// USI request and response structs, TFT timing and pixel
//----------------------------------------------------------
`include "usi_consts.svh"
`default_nettype none

package usiPkg;

	// One request from the active master
	typedef struct packed {
		logic [`USI_DATA_WIDTH-1:0] wd;
		logic [`USI_ADRS_WIDTH-1:0] adrs;
		logic                       wEd;
		logic                       rEd;
	} usiReq_t;

	// rd stays zero while rVd is low
	typedef struct packed {
		logic [`USI_DATA_WIDTH-1:0] rd;
		logic                       rVd;
	} usiRsp_t;

	// Syncs are active low
	typedef struct packed {
		logic hSync;
		logic vSync;
		logic de;
	} tftTiming_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb444_t;

endpackage

`default_nettype wire

// ==== design/usiBus.sv ====
//----------------------------------------------------------
// USI bus: master select, request broadcast and
// response collection
//----------------------------------------------------------
`timescale 1ns/1ps
`include "usi_consts.svh"
`default_nettype none

module usiBus (
	input  wire                  sysClk,
	input  wire                  arstN,
	input  wire                  masterSel,
	input  wire usiPkg::usiReq_t hostReq,
	input  wire usiPkg::usiReq_t dbgReq,
	output wire usiPkg::usiReq_t slvReq,
	input  wire usiPkg::usiRsp_t gpioRsp,
	input  wire usiPkg::usiRsp_t vtbRsp,
	output usiPkg::usiRsp_t      hostRsp
);
	import usiPkg::*;

	usiReq_t                    reqSel;
	usiRsp_t                    rspOr;
	logic [`USI_DATA_WIDTH-1:0] wdQ;
	logic [`USI_ADRS_WIDTH-1:0] adrsQ;
	logic                       wEdQ;
	logic                       rEdQ;

	//----------------------------------------------------------
	// Master to slave
	//----------------------------------------------------------
	// 1 selects the debug port (SPI master side)
	assign reqSel = masterSel ? dbgReq : hostReq;

	always_ff @(posedge sysClk)
	begin
		wdQ   <= reqSel.wd;
		adrsQ <= reqSel.adrs;
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			wEdQ <= 1'b0;
			rEdQ <= 1'b0;
		end
		else
		begin
			wEdQ <= reqSel.wEd;
			rEdQ <= reqSel.rEd;
		end
	end

	// Every slave sees the same request and decodes its own block
	assign slvReq = '{wd: wdQ, adrs: adrsQ, wEd: wEdQ, rEd: rEdQ};

	//----------------------------------------------------------
	// Slave to master
	//----------------------------------------------------------
	// Idle slaves drive zero, so a plain OR merges them
	always_comb
	begin
		rspOr.rd  = gpioRsp.rd | vtbRsp.rd;
		rspOr.rVd = gpioRsp.rVd | vtbRsp.rVd;
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hostRsp <= '0;
		end
		else
		begin
			hostRsp <= rspOr;
		end
	end

endmodule

`default_nettype wire

// ==== design/gpioBlock.sv ====
//----------------------------------------------------------
// GPIO block: LED and RGB LED registers with readback
//----------------------------------------------------------
`timescale 1ns/1ps
`include "usi_consts.svh"
`default_nettype none

module gpioBlock (
	input  wire                  sysClk,
	input  wire                  arstN,
	input  wire usiPkg::usiReq_t slvReq,
	output usiPkg::usiRsp_t      rsp,
	output wire [1:0]            led,
	output wire                  ledB,
	output wire                  ledG,
	output wire                  ledR
);
	import usiPkg::*;

	localparam logic [`USI_CSR_WIDTH-1:0] offsLed = 'h00;
	localparam logic [`USI_CSR_WIDTH-1:0] offsRgb = 'h04;

	logic                       hit;
	logic [`USI_CSR_WIDTH-1:0]  offset;
	logic [1:0]                 ledQ;
	logic [2:0]                 rgbQ;
	logic [`USI_DATA_WIDTH-1:0] rdMux;
	usiRsp_t                    rspD;

	assign hit    = slvReq.adrs[`USI_BLOCK_LSB +: 4] == `USI_BLOCK_GPIO;
	assign offset = slvReq.adrs[`USI_CSR_WIDTH-1:0];

	// CSR writes
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			ledQ <= '0;
			rgbQ <= '0;
		end
		else if (slvReq.wEd && hit)
		begin
			if (offset == offsLed)
				ledQ <= slvReq.wd[1:0];
			if (offset == offsRgb)
				rgbQ <= slvReq.wd[2:0];
		end
	end

	// Readback, zero extended
	always_comb
	begin
		rdMux = '0;
		case (offset)
			offsLed: rdMux[1:0] = ledQ;
			offsRgb: rdMux[2:0] = rgbQ;
			default: rdMux = '0;
		endcase
		rspD.rVd = slvReq.rEd && hit;
		rspD.rd  = rspD.rVd ? rdMux : '0;
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			rsp <= '0;
		else
			rsp <= rspD;
	end

	assign led  = ledQ;
	assign ledR = rgbQ[0];
	assign ledG = rgbQ[1];
	assign ledB = rgbQ[2];

endmodule

`default_nettype wire

// ==== design/videoTimingGen.sv ====
//----------------------------------------------------------
// TFT display timing: line and frame counters,
// registered syncs, data enable and frame start
//----------------------------------------------------------
`timescale 1ns/1ps
`include "usi_consts.svh"
`default_nettype none

module videoTimingGen (
	input  wire                     sysClk,
	input  wire                     arstN,
	input  wire                     enable,
	input  wire [`TFT_H_WIDTH-1:0]  hDisplay,
	input  wire [`TFT_H_WIDTH-1:0]  hFront,
	input  wire [`TFT_H_WIDTH-1:0]  hBack,
	input  wire [`TFT_H_WIDTH-1:0]  hPulse,
	input  wire [`TFT_V_WIDTH-1:0]  vDisplay,
	input  wire [`TFT_V_WIDTH-1:0]  vFront,
	input  wire [`TFT_V_WIDTH-1:0]  vBack,
	input  wire [`TFT_V_WIDTH-1:0]  vPulse,
	output usiPkg::tftTiming_t      timing,
	output logic                    frameStart
);
	import usiPkg::*;

	logic [`TFT_H_WIDTH-1:0] hDispL, hFrontL, hBackL, hPulseL;
	logic [`TFT_V_WIDTH-1:0] vDispL, vFrontL, vBackL, vPulseL;
	logic [`TFT_H_WIDTH-1:0] hCnt, hSyncStart, hSyncEnd, hLast;
	logic [`TFT_V_WIDTH-1:0] vCnt, vSyncStart, vSyncEnd, vLast;
	logic                    lineEnd;
	logic                    frameEnd;
	tftTiming_t              timingD;

	//----------------------------------------------------------
	// Timing set in use
	//----------------------------------------------------------
	// Reloaded while idle and on the last pixel, so a new set
	// starts with the next frame
	always_ff @(posedge sysClk)
	begin
		if (!enable || frameEnd)
		begin
			hDispL  <= hDisplay;
			hFrontL <= hFront;
			hBackL  <= hBack;
			hPulseL <= hPulse;
			vDispL  <= vDisplay;
			vFrontL <= vFront;
			vBackL  <= vBack;
			vPulseL <= vPulse;
		end
	end

	// Order within a line: display, front porch, pulse, back porch
	assign hSyncStart = hDispL + hFrontL;
	assign hSyncEnd   = hSyncStart + hPulseL;
	assign hLast      = hSyncEnd + hBackL - 1'b1;
	assign vSyncStart = vDispL + vFrontL;
	assign vSyncEnd   = vSyncStart + vPulseL;
	assign vLast      = vSyncEnd + vBackL - 1'b1;

	assign lineEnd  = hCnt == hLast;
	assign frameEnd = lineEnd && (vCnt == vLast);

	//----------------------------------------------------------
	// Counters
	//----------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (!enable)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (lineEnd)
		begin
			hCnt <= '0;
			vCnt <= (vCnt == vLast) ? '0 : vCnt + 1'b1;
		end
		else
		begin
			hCnt <= hCnt + 1'b1;
		end
	end

	always_comb
	begin
		timingD.hSync = !(enable && hCnt >= hSyncStart && hCnt < hSyncEnd);
		timingD.vSync = !(enable && vCnt >= vSyncStart && vCnt < vSyncEnd);
		timingD.de    = enable && hCnt < hDispL && vCnt < vDispL;
	end

	// Outputs lag the counters by one cycle
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			timing     <= '{hSync: 1'b1, vSync: 1'b1, de: 1'b0};
			frameStart <= 1'b0;
		end
		else
		begin
			timing     <= timingD;
			frameStart <= enable && hCnt == '0 && vCnt == '0;
		end
	end

endmodule

`default_nettype wire

// ==== design/videoTxBlock.sv ====
//----------------------------------------------------------
// Video transmit block: CSR bank, fill colour, backlight
// and the display timing generator
//----------------------------------------------------------
`timescale 1ns/1ps
`include "usi_consts.svh"
`default_nettype none

module videoTxBlock (
	input  wire                  sysClk,
	input  wire                  arstN,
	input  wire usiPkg::usiReq_t slvReq,
	output usiPkg::usiRsp_t      rsp,
	output usiPkg::tftTiming_t   tft,
	output usiPkg::rgb444_t      tftColor,
	output wire                  tftBackLight
);
	import usiPkg::*;

	localparam logic [`TFT_H_WIDTH-1:0] hDisplayDef = `TFT_HDISPLAY_DEF;
	localparam logic [`TFT_H_WIDTH-1:0] hFrontDef   = `TFT_HFRONT_DEF;
	localparam logic [`TFT_H_WIDTH-1:0] hBackDef    = `TFT_HBACK_DEF;
	localparam logic [`TFT_H_WIDTH-1:0] hPulseDef   = `TFT_HPULSE_DEF;
	localparam logic [`TFT_V_WIDTH-1:0] vDisplayDef = `TFT_VDISPLAY_DEF;
	localparam logic [`TFT_V_WIDTH-1:0] vFrontDef   = `TFT_VFRONT_DEF;
	localparam logic [`TFT_V_WIDTH-1:0] vBackDef    = `TFT_VBACK_DEF;
	localparam logic [`TFT_V_WIDTH-1:0] vPulseDef   = `TFT_VPULSE_DEF;

	logic                       hit;
	logic [`USI_CSR_WIDTH-1:0]  offset;
	logic [1:0]                 ctrlQ;
	rgb444_t                    fillQ, fillActive, fillNow;
	logic [`TFT_H_WIDTH-1:0]    hDisplayQ, hFrontQ, hBackQ, hPulseQ;
	logic [`TFT_V_WIDTH-1:0]    vDisplayQ, vFrontQ, vBackQ, vPulseQ;
	logic [`USI_DATA_WIDTH-1:0] rdMux;
	usiRsp_t                    rspD;
	tftTiming_t                 genTiming;
	logic                       frameStart;

	assign hit    = slvReq.adrs[`USI_BLOCK_LSB +: 4] == `USI_BLOCK_VTB;
	assign offset = slvReq.adrs[`USI_CSR_WIDTH-1:0];

	//----------------------------------------------------------
	// CSR bank
	//----------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			ctrlQ     <= '0;
			fillQ     <= '0;
			hDisplayQ <= hDisplayDef;
			hFrontQ   <= hFrontDef;
			hBackQ    <= hBackDef;
			hPulseQ   <= hPulseDef;
			vDisplayQ <= vDisplayDef;
			vFrontQ   <= vFrontDef;
			vBackQ    <= vBackDef;
			vPulseQ   <= vPulseDef;
		end
		else if (slvReq.wEd && hit)
		begin
			case (offset)
				'h00: ctrlQ     <= slvReq.wd[1:0];
				'h04: fillQ     <= rgb444_t'(slvReq.wd[11:0]);
				'h10: hDisplayQ <= slvReq.wd[`TFT_H_WIDTH-1:0];
				'h14: hFrontQ   <= slvReq.wd[`TFT_H_WIDTH-1:0];
				'h18: hBackQ    <= slvReq.wd[`TFT_H_WIDTH-1:0];
				'h1C: hPulseQ   <= slvReq.wd[`TFT_H_WIDTH-1:0];
				'h20: vDisplayQ <= slvReq.wd[`TFT_V_WIDTH-1:0];
				'h24: vFrontQ   <= slvReq.wd[`TFT_V_WIDTH-1:0];
				'h28: vBackQ    <= slvReq.wd[`TFT_V_WIDTH-1:0];
				'h2C: vPulseQ   <= slvReq.wd[`TFT_V_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	always_comb
	begin
		rdMux = '0;
		case (offset)
			'h00: rdMux[1:0]              = ctrlQ;
			'h04: rdMux[11:0]             = fillQ;
			'h10: rdMux[`TFT_H_WIDTH-1:0] = hDisplayQ;
			'h14: rdMux[`TFT_H_WIDTH-1:0] = hFrontQ;
			'h18: rdMux[`TFT_H_WIDTH-1:0] = hBackQ;
			'h1C: rdMux[`TFT_H_WIDTH-1:0] = hPulseQ;
			'h20: rdMux[`TFT_V_WIDTH-1:0] = vDisplayQ;
			'h24: rdMux[`TFT_V_WIDTH-1:0] = vFrontQ;
			'h28: rdMux[`TFT_V_WIDTH-1:0] = vBackQ;
			'h2C: rdMux[`TFT_V_WIDTH-1:0] = vPulseQ;
			default: rdMux = '0;
		endcase
		rspD.rVd = slvReq.rEd && hit;
		rspD.rd  = rspD.rVd ? rdMux : '0;
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			rsp <= '0;
		else
			rsp <= rspD;
	end

	//----------------------------------------------------------
	// Display path
	//----------------------------------------------------------
	videoTimingGen timingGen_i (
		.sysClk     (sysClk),
		.arstN      (arstN),
		.enable     (ctrlQ[0]),
		.hDisplay   (hDisplayQ),
		.hFront     (hFrontQ),
		.hBack      (hBackQ),
		.hPulse     (hPulseQ),
		.vDisplay   (vDisplayQ),
		.vFront     (vFrontQ),
		.vBack      (vBackQ),
		.vPulse     (vPulseQ),
		.timing     (genTiming),
		.frameStart (frameStart)
	);

	// Colour changes only on a frame boundary
	assign fillNow = frameStart ? fillQ : fillActive;

	always_ff @(posedge sysClk)
	begin
		if (frameStart)
			fillActive <= fillQ;
	end

	// Timing is delayed with the colour so both leave together
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			tft      <= '{hSync: 1'b1, vSync: 1'b1, de: 1'b0};
			tftColor <= '0;
		end
		else
		begin
			tft      <= genTiming;
			tftColor <= genTiming.de ? fillNow : '0;
		end
	end

	assign tftBackLight = ctrlQ[1];

endmodule

`default_nettype wire

// ==== design/processer.sv ====
//----------------------------------------------------------
// Processor top: USI bus with GPIO and video slaves
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module processer (
	input  wire                     sysClk,
	input  wire                     arstN,
	input  wire                     masterSel,
	input  wire usiPkg::usiReq_t    hostReq,
	input  wire usiPkg::usiReq_t    dbgReq,
	output wire usiPkg::usiRsp_t    hostRsp,
	output wire [1:0]               led,
	output wire                     ledB,
	output wire                     ledG,
	output wire                     ledR,
	output wire usiPkg::tftTiming_t tft,
	output wire usiPkg::rgb444_t    tftColor,
	output wire                     tftBackLight
);
	import usiPkg::*;

	// Broadcast request and per slave responses
	wire usiReq_t slvReq;
	wire usiRsp_t gpioRsp;
	wire usiRsp_t vtbRsp;

	usiBus usiBus_i (
		.sysClk    (sysClk),
		.arstN     (arstN),
		.masterSel (masterSel),
		.hostReq   (hostReq),
		.dbgReq    (dbgReq),
		.slvReq    (slvReq),
		.gpioRsp   (gpioRsp),
		.vtbRsp    (vtbRsp),
		.hostRsp   (hostRsp)
	);

	gpioBlock gpio_i (
		.sysClk (sysClk),
		.arstN  (arstN),
		.slvReq (slvReq),
		.rsp    (gpioRsp),
		.led    (led),
		.ledB   (ledB),
		.ledG   (ledG),
		.ledR   (ledR)
	);

	videoTxBlock vtb_i (
		.sysClk       (sysClk),
		.arstN        (arstN),
		.slvReq       (slvReq),
		.rsp          (vtbRsp),
		.tft          (tft),
		.tftColor     (tftColor),
		.tftBackLight (tftBackLight)
	);

endmodule

`default_nettype wire

// ==== bench/tbClock.sv ====
//----------------------------------------------------------
// Testbench clock and reset generator
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic arstN
);
	localparam int halfPeriod = 10;
	localparam int resetCycles = 16;

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Release lines up with the stimulus drive point
	initial
	begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#2 arstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/processer_assertions.sv ====
//----------------------------------------------------------
// Concurrent checks on the processor top, bound to processer
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module processer_assertions (
	input wire                     sysClk,
	input wire                     arstN,
	input wire                     masterSel,
	input wire usiPkg::usiReq_t    hostReq,
	input wire usiPkg::usiReq_t    dbgReq,
	input wire usiPkg::usiRsp_t    hostRsp,
	input wire usiPkg::tftTiming_t tft
);
	logic readSel;

	// Read strobe of the active master
	assign readSel = masterSel ? dbgReq.rEd : hostReq.rEd;

	// A read sampled at edge k answers at edge k+3
	rspPairNeedsTwoReads: assert property (
		@(posedge sysClk) disable iff (!arstN)
		hostRsp.rVd && $past(hostRsp.rVd) |-> $past(readSel, 3) && $past(readSel, 4)
	) else $error("hostRsp.rVd high twice in a row without two reads");

	deOnlyOutsideSync: assert property (
		@(posedge sysClk) disable iff (!arstN)
		tft.de |-> tft.hSync && tft.vSync
	) else $error("tft.de high while a sync is active");

	rdZeroWhenIdle: assert property (
		@(posedge sysClk) disable iff (!arstN)
		!hostRsp.rVd |-> hostRsp.rd == '0
	) else $error("hostRsp.rd not zero while rVd is low");

endmodule

bind processer processer_assertions assertions_i (
	.sysClk    (sysClk),
	.arstN     (arstN),
	.masterSel (masterSel),
	.hostReq   (hostReq),
	.dbgReq    (dbgReq),
	.hostRsp   (hostRsp),
	.tft       (tft)
);

`default_nettype wire

// ==== bench/tbProcesser.sv ====
//----------------------------------------------------------
// Processor testbench: CSR shadow model, random stimulus,
// bus latency, master select and display timing checks
//----------------------------------------------------------
`timescale 1ns/1ps
`include "usi_consts.svh"
`default_nettype none

module tbProcesser;
	import usiPkg::*;

	localparam int readTimeout = 8;
	localparam int gpio = `USI_BLOCK_GPIO;
	localparam int vtb = `USI_BLOCK_VTB;

	wire         sysClk;
	wire         arstN;
	logic        masterSel;
	usiReq_t     hostReq;
	usiReq_t     dbgReq;
	usiRsp_t     hostRsp;
	logic [1:0]  led;
	logic        ledB, ledG, ledR;
	tftTiming_t  tft;
	rgb444_t     tftColor;
	logic        tftBackLight;
	int          errorCount;
	int          checkCount;
	// Shadow CSRs, indexed by block and offset/4
	logic [31:0] shadow [0:7][0:15];

	tbClock clock_i (.clk(sysClk), .arstN(arstN));

	processer dut_i (
		.sysClk (sysClk), .arstN (arstN), .masterSel (masterSel),
		.hostReq (hostReq), .dbgReq (dbgReq), .hostRsp (hostRsp),
		.led (led), .ledB (ledB), .ledG (ledG), .ledR (ledR),
		.tft (tft), .tftColor (tftColor), .tftBackLight (tftBackLight)
	);

	//----------------------------------------------------------
	// Helpers
	//----------------------------------------------------------
	task automatic tick();
		@(posedge sysClk);
		#2;
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("ERROR %s", what);
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		$display("test %s done with %0d errors", name, errorCount - errorsBefore);
	endtask

	// Writable bits per register, from the address map
	function automatic logic [31:0] csrMask(input int block, input int offset);
		if (block == gpio)
			return (offset == 0) ? 32'h3 : (offset == 4) ? 32'h7 : 32'h0;
		if (block == vtb)
		begin
			if (offset == 0)
				return 32'h3;
			if (offset == 4)
				return 32'hfff;
			if (offset >= 'h10 && offset <= 'h1C)
				return (32'h1 << `TFT_H_WIDTH) - 1;
			if (offset >= 'h20 && offset <= 'h2C)
				return (32'h1 << `TFT_V_WIDTH) - 1;
		end
		return 32'h0;
	endfunction

	function automatic usiReq_t makeReq(input int block, input int offset,
		input logic [31:0] data, input logic wr, input logic rd);
		usiReq_t req;
		req.wd   = data;
		req.adrs = (block << `USI_BLOCK_LSB) | offset;
		req.wEd  = wr;
		req.rEd  = rd;
		return req;
	endfunction

	task automatic driveActive(input usiReq_t req);
		if (masterSel)
			dbgReq = req;
		else
			hostReq = req;
	endtask

	task automatic idleBus();
		hostReq = '0;
		dbgReq  = '0;
	endtask

	// Returns with the write visible on the register outputs
	task automatic writeCsr(input int block, input int offset, input logic [31:0] data);
		driveActive(makeReq(block, offset, data, 1'b1, 1'b0));
		shadow[block][offset >> 2] = data & csrMask(block, offset);
		tick();
		idleBus();
		tick();
	endtask

	task automatic readCsr(input int block, input int offset, output logic [31:0] data,
		output int latency);
		int step;
		latency = -1;
		data    = '0;
		driveActive(makeReq(block, offset, 32'h0, 1'b0, 1'b1));
		for (step = 1; step <= readTimeout && latency < 0; step++)
		begin
			tick();
			idleBus();
			if (hostRsp.rVd)
			begin
				latency = step;
				data    = hostRsp.rd;
			end
		end
	endtask

	task automatic readAndCheck(input int block, input int offset, input string name);
		logic [31:0] data;
		int          latency;
		readCsr(block, offset, data, latency);
		if (latency < 0)
			reportFailure($sformatf("no read response from block %0d offset 0x%0h",
				block, offset));
		else
		begin
			checkValue(name, shadow[block][offset >> 2], data);
			checkValue({name, " latency"}, 3, latency);
		end
	endtask

	task automatic checkPins();
		checkValue("led", shadow[gpio][0][1:0], led);
		checkValue("ledR", shadow[gpio][1][0], ledR);
		checkValue("ledG", shadow[gpio][1][1], ledG);
		checkValue("ledB", shadow[gpio][1][2], ledB);
	endtask

	task automatic initShadow();
		for (int b = 0; b < 8; b++)
			for (int o = 0; o < 16; o++)
				shadow[b][o] = '0;
		shadow[vtb][4]  = `TFT_HDISPLAY_DEF;
		shadow[vtb][5]  = `TFT_HFRONT_DEF;
		shadow[vtb][6]  = `TFT_HBACK_DEF;
		shadow[vtb][7]  = `TFT_HPULSE_DEF;
		shadow[vtb][8]  = `TFT_VDISPLAY_DEF;
		shadow[vtb][9]  = `TFT_VFRONT_DEF;
		shadow[vtb][10] = `TFT_VBACK_DEF;
		shadow[vtb][11] = `TFT_VPULSE_DEF;
	endtask

	//----------------------------------------------------------
	// Tests
	//----------------------------------------------------------
	task automatic testResetDefaults();
		int errorsBefore;
		errorsBefore = errorCount;
		checkPins();
		checkValue("tft.de", 0, tft.de);
		checkValue("tft.hSync", 1, tft.hSync);
		checkValue("tft.vSync", 1, tft.vSync);
		checkValue("tftBackLight", 0, tftBackLight);
		checkValue("hostRsp.rVd", 0, hostRsp.rVd);
		for (int off = 'h10; off <= 'h2C; off += 4)
			readAndCheck(vtb, off, $sformatf("vtb default 0x%0h", off));
		finishTest("reset defaults", errorsBefore);
	endtask

	task automatic testGpioWrites();
		int errorsBefore;
		int off;
		errorsBefore = errorCount;
		for (int n = 0; n < 10; n++)
		begin
			off = ($urandom % 2) * 4;
			writeCsr(gpio, off, $urandom);
			checkPins();
			readAndCheck(gpio, off, $sformatf("gpio 0x%0h", off));
		end
		finishTest("gpio writes", errorsBefore);
	endtask

	// The inactive port carries a clashing write in the same cycle
	task automatic testMasterSelect();
		int          errorsBefore;
		logic [31:0] value;
		errorsBefore = errorCount;
		masterSel = 1'b1;
		value = $urandom;
		hostReq = makeReq(gpio, 0, ~value, 1'b1, 1'b0);
		writeCsr(gpio, 0, value);
		checkPins();
		readAndCheck(gpio, 0, "led via dbgReq");
		masterSel = 1'b0;
		value = $urandom;
		dbgReq = makeReq(gpio, 4, ~value, 1'b1, 1'b0);
		writeCsr(gpio, 4, value);
		checkPins();
		readAndCheck(gpio, 4, "rgb via hostReq");
		finishTest("master select", errorsBefore);
	endtask

	task automatic testReadLatency();
		int          errorsBefore;
		int          got;
		int          blocks [0:2];
		int          offs [0:2];
		logic [31:0] data;
		int          latency;
		errorsBefore = errorCount;
		blocks = '{gpio, vtb, gpio};
		offs   = '{'h04, 'h14, 'h00};
		got    = 0;
		driveActive(makeReq(blocks[0], offs[0], 32'h0, 1'b0, 1'b1));
		for (int step = 1; step < 12; step++)
		begin
			tick();
			if (hostRsp.rVd && got < 3)
			begin
				checkValue("back-to-back rVd step", got + 3, step);
				checkValue("back-to-back rd", shadow[blocks[got]][offs[got] >> 2], hostRsp.rd);
				got++;
			end
			else if (hostRsp.rVd)
				reportFailure("extra read response after three reads");
			if (step < 3)
				driveActive(makeReq(blocks[step], offs[step], 32'h0, 1'b0, 1'b1));
			else
				idleBus();
		end
		if (got != 3)
			reportFailure($sformatf("only %0d of 3 back-to-back reads answered", got));
		readCsr(7, 0, data, latency);
		if (latency >= 0)
			reportFailure("read to unmapped block 7 returned a response");
		finishTest("read latency", errorsBefore);
	endtask

	task automatic testVideoCsr();
		int errorsBefore;
		errorsBefore = errorCount;
		for (int off = 0; off <= 'h2C; off += 4)
			if (off != 'h08 && off != 'h0C)
				writeCsr(vtb, off, $urandom);
		for (int off = 0; off <= 'h2C; off += 4)
			readAndCheck(vtb, off, $sformatf("vtb 0x%0h", off));
		finishTest("video csr", errorsBefore);
	endtask

	task automatic testVideoTiming();
		int          errorsBefore;
		int          hDisp, hFr, hBk, hPl, vDisp, vFr, vBk, vPl;
		int          lineLen, frameLen, samples;
		int          lastHFall, hLow, deRun, deLines, lastVFall, vLow, vFalls;
		logic [11:0] fill;
		logic        backLight;
		tftTiming_t  prevT;
		errorsBefore = errorCount;
		hDisp = 4 + $urandom % 8;
		hFr   = 1 + $urandom % 4;
		hBk   = 1 + $urandom % 4;
		hPl   = 1 + $urandom % 4;
		vDisp = 2 + $urandom % 4;
		vFr   = 1 + $urandom % 3;
		vBk   = 1 + $urandom % 3;
		vPl   = 1 + $urandom % 3;
		fill      = $urandom;
		backLight = $urandom;
		lineLen   = hDisp + hFr + hPl + hBk;
		frameLen  = vDisp + vFr + vPl + vBk;
		writeCsr(vtb, 'h00, 0);
		writeCsr(vtb, 'h04, fill);
		writeCsr(vtb, 'h10, hDisp);
		writeCsr(vtb, 'h14, hFr);
		writeCsr(vtb, 'h18, hBk);
		writeCsr(vtb, 'h1C, hPl);
		writeCsr(vtb, 'h20, vDisp);
		writeCsr(vtb, 'h24, vFr);
		writeCsr(vtb, 'h28, vBk);
		writeCsr(vtb, 'h2C, vPl);
		writeCsr(vtb, 'h00, {backLight, 1'b1});
		checkValue("tftBackLight", backLight, tftBackLight);

		// Measure edges and runs on the fly over two frames
		samples   = 2 * lineLen * frameLen + lineLen + 20;
		lastHFall = -1;
		lastVFall = -1;
		hLow      = 0;
		vLow      = 0;
		deRun     = 0;
		deLines   = 0;
		vFalls    = 0;
		prevT     = tft;
		for (int i = 0; i < samples; i++)
		begin
			tick();
			if (prevT.hSync && !tft.hSync)
			begin
				if (lastHFall >= 0)
					checkValue("hSync period", lineLen, i - lastHFall);
				lastHFall = i;
				hLow      = 0;
			end
			if (!tft.hSync)
				hLow++;
			if (!prevT.hSync && tft.hSync && lastHFall >= 0)
				checkValue("hSync low width", hPl, hLow);
			if (tft.de)
				deRun++;
			if (prevT.de && !tft.de)
			begin
				checkValue("de cycles per line", hDisp, deRun);
				deRun = 0;
				deLines++;
			end
			if (prevT.vSync && !tft.vSync)
			begin
				checkValue("de lines per frame", vDisp, deLines);
				if (lastVFall >= 0)
					checkValue("frame length", lineLen * frameLen, i - lastVFall);
				deLines   = 0;
				lastVFall = i;
				vLow      = 0;
				vFalls++;
			end
			if (!tft.vSync)
				vLow++;
			if (!prevT.vSync && tft.vSync && lastVFall >= 0)
				checkValue("vSync low cycles", vPl * lineLen, vLow);
			checkValue("tftColor", tft.de ? {20'h0, fill} : 32'h0, tftColor);
			prevT = tft;
		end
		if (vFalls < 2)
			reportFailure($sformatf("only %0d vSync pulses seen in two frames", vFalls));
		finishTest("video timing", errorsBefore);
	endtask

	//----------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------
	initial
	begin
		int waitCycles;
		void'($urandom(32'h6a9a));
		masterSel  = 1'b0;
		hostReq    = '0;
		dbgReq     = '0;
		errorCount = 0;
		checkCount = 0;
		initShadow();
		waitCycles = 0;
		while (arstN !== 1'b1 && waitCycles < 40)
		begin
			@(posedge sysClk);
			waitCycles++;
		end
		if (arstN === 1'b1)
		begin
			tick();
			testResetDefaults();
			testGpioWrites();
			testMasterSelect();
			testReadLatency();
			testVideoCsr();
			testVideoTiming();
		end
		else
			reportFailure("reset was never released");
		$display("checks run %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Stops a run that hangs
	initial
	begin
		#1_000_000;
		$display("Simulation did not finish within the time limit");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/usiPkg.sv
design/usiBus.sv
design/gpioBlock.sv
design/videoTimingGen.sv
design/videoTxBlock.sv
design/processer.sv
bench/tbClock.sv
bench/processer_assertions.sv
bench/tbProcesser.sv

// ==== Bender.yml ====
package:
  name: processer

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/usiPkg.sv
      - design/usiBus.sv
      - design/gpioBlock.sv
      - design/videoTimingGen.sv
      - design/videoTxBlock.sv
      - design/processer.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/tbClock.sv
      - bench/processer_assertions.sv
      - bench/tbProcesser.sv
